// ==== src/side_ch_pkg.sv ====
// side channel package: widths, limits, trigger codes, output modes and shared structs
package side_ch_pkg;

	localparam int iq_data_width = 16; // one I or Q component
	localparam int iq_pair_width = 2 * iq_data_width;
	localparam int dma_data_width = 64;
	localparam int tsf_width = 64;
	localparam int gpio_status_width = 8; // msb agc lock, low bits gain
	localparam int rssi_width = 11; // signed, half dB steps

	localparam int max_num_dma_symbol = 8192;
	// 65507 byte udp payload / 8 bytes per word
	localparam int max_num_dma_symbol_udp = 8188;
	localparam int dma_count_width = 14;
	localparam int iq_addr_width = 13;
	localparam int num_dma_symbol_reg_addr = 2; // write here kicks an auto transfer

	// trigger codes, gaps are codes not implemented here
	localparam logic [4:0] trig_fcs_any = 5'd0;
	localparam logic [4:0] trig_fcs_ok = 5'd1;
	localparam logic [4:0] trig_fcs_bad = 5'd2;
	localparam logic [4:0] trig_header_ok = 5'd4;
	localparam logic [4:0] trig_header_bad = 5'd5;
	localparam logic [4:0] trig_long_preamble = 5'd8;
	localparam logic [4:0] trig_short_preamble = 5'd9;
	localparam logic [4:0] trig_rssi_rise = 5'd10;
	localparam logic [4:0] trig_rssi_fall = 5'd11;
	localparam logic [4:0] trig_agc_unlock = 5'd12;
	localparam logic [4:0] trig_agc_lock = 5'd13;
	localparam logic [4:0] trig_gain_rise = 5'd14;
	localparam logic [4:0] trig_gain_fall = 5'd15;
	localparam logic [4:0] trig_phy_tx_done = 5'd17;
	localparam logic [4:0] trig_tx_bb_rise = 5'd18;
	localparam logic [4:0] trig_tx_bb_fall = 5'd19;
	localparam logic [4:0] trig_tx_rf_rise = 5'd20;
	localparam logic [4:0] trig_tx_rf_fall = 5'd21;

	// what the dma port sees
	localparam logic [1:0] mode_loopback = 2'd0;
	localparam logic [1:0] mode_auto_start = 2'd1;
	localparam logic [1:0] mode_ext_start = 2'd2;
	localparam logic [1:0] mode_idle = 2'd3;

	typedef struct packed {
		logic [iq_pair_width-1:0] iq0;
		logic [iq_pair_width-1:0] iq1;
		logic strobe;
	} iq_stream_t;

	typedef struct packed {
		logic fcs_in_strobe;
		logic fcs_ok;
		logic pkt_header_valid_strobe;
		logic pkt_header_valid;
		logic ht_flag;
		logic long_preamble_detected;
		logic short_preamble_detected;
		logic demod_is_ongoing;
	} rx_events_t;

	typedef struct packed {
		logic phy_tx_done;
		logic tx_bb_is_ongoing;
		logic tx_rf_is_ongoing;
	} tx_status_t;

	typedef struct packed {
		logic iq_capture;
		logic dual_iq; // 1: {iq1,iq0}, 0: status + iq0
		logic [1:0] source_sel;
		logic [4:0] trigger_sel;
		logic free_run;
		logic signed [rssi_width-1:0] rssi_th;
		logic [gpio_status_width-2:0] gain_th;
		logic [dma_count_width-1:0] pre_trigger_len;
		logic [dma_count_width-1:0] iq_len;
	} capture_cfg_t;

	typedef struct packed {
		logic [dma_data_width-1:0] data;
		logic valid;
	} dma_word_t;

endpackage

// ==== src/iq_sample_packer.sv ====
// iq_sample_packer: source mux, fcs-ok flag and capture word formatting
module iq_sample_packer import side_ch_pkg::*; (
	input  logic clk,
	input  logic rstn,
	input  iq_stream_t rx_iq,
	input  iq_stream_t ofdm_tx_iq,
	input  iq_stream_t intf_tx_iq,
	input  rx_events_t rx_events,
	input  logic tx_rf_is_ongoing,
	input  logic signed [rssi_width-1:0] rssi_half_db,
	input  logic [gpio_status_width-1:0] gpio_status,
	input  capture_cfg_t cfg,
	output logic [dma_data_width-1:0] sample_word,
	output logic sample_strobe
);

	iq_stream_t src;
	logic fcs_ok_flag;

	always_comb begin
		case (cfg.source_sel)
			2'd0: src = rx_iq;
			2'd1: src = ofdm_tx_iq;
			default: src = intf_tx_iq; // 2 and 3 both pick tx_intf
		endcase
	end

	// set on a good fcs, dropped when the next packet starts decoding
	always_ff @(posedge clk) begin
		if (!rstn) begin
			fcs_ok_flag <= 1'b0;
		end else if (rx_events.fcs_in_strobe && rx_events.fcs_ok) begin
			fcs_ok_flag <= 1'b1;
		end else if (rx_events.long_preamble_detected) begin
			fcs_ok_flag <= 1'b0;
		end
	end

	always_comb begin
		if (cfg.dual_iq) begin
			sample_word = {src.iq1, src.iq0};
		end else begin
			sample_word = {rx_events.demod_is_ongoing,
				tx_rf_is_ongoing,
				fcs_ok_flag,
				rssi_half_db, // bits 60:50
				10'd0,
				gpio_status, // bits 39:32
				src.iq0};
		end
	end

	assign sample_strobe = src.strobe & cfg.iq_capture;

endmodule

// ==== src/iq_trigger_select.sv ====
// iq_trigger_select: level edge detectors and registered trigger code selection
module iq_trigger_select import side_ch_pkg::*; (
	input  logic clk,
	input  logic rstn,
	input  capture_cfg_t cfg,
	input  rx_events_t rx_events,
	input  tx_status_t tx_status,
	input  logic signed [rssi_width-1:0] rssi_half_db,
	input  logic [gpio_status_width-1:0] gpio_status,
	output logic trigger
);

	localparam int gain_width = gpio_status_width - 1;

	logic signed [rssi_width-1:0] rssi_th;
	logic signed [rssi_width-1:0] rssi_reg;
	logic [gpio_status_width-1:0] gpio_reg;
	logic tx_bb_reg;
	logic tx_rf_reg;

	logic rssi_rise, rssi_fall;
	logic agc_unlock, agc_lock;
	logic gain_rise, gain_fall;
	logic tx_bb_rise, tx_bb_fall;
	logic tx_rf_rise, tx_rf_fall;
	logic trig_cond;

	logic agc_now, agc_prev;
	logic [gain_width-1:0] gain_now, gain_prev;

	assign rssi_th = cfg.rssi_th;
	assign agc_now = gpio_status[gpio_status_width-1];
	assign agc_prev = gpio_reg[gpio_status_width-1];
	assign gain_now = gpio_status[gain_width-1:0];
	assign gain_prev = gpio_reg[gain_width-1:0];

	// level history plus one registered stage of edge flags
	always_ff @(posedge clk) begin
		if (!rstn) begin
			rssi_reg <= '0;
			gpio_reg <= '0;
			tx_bb_reg <= 1'b0;
			tx_rf_reg <= 1'b0;
			rssi_rise <= 1'b0;
			rssi_fall <= 1'b0;
			agc_unlock <= 1'b0;
			agc_lock <= 1'b0;
			gain_rise <= 1'b0;
			gain_fall <= 1'b0;
			tx_bb_rise <= 1'b0;
			tx_bb_fall <= 1'b0;
			tx_rf_rise <= 1'b0;
			tx_rf_fall <= 1'b0;
		end else begin
			rssi_reg <= rssi_half_db;
			gpio_reg <= gpio_status;
			tx_bb_reg <= tx_status.tx_bb_is_ongoing;
			tx_rf_reg <= tx_status.tx_rf_is_ongoing;

			rssi_rise <= (rssi_reg < rssi_th) && (rssi_half_db >= rssi_th);
			rssi_fall <= (rssi_reg >= rssi_th) && (rssi_half_db < rssi_th);
			agc_unlock <= agc_prev && !agc_now;
			agc_lock <= !agc_prev && agc_now;
			gain_rise <= (gain_prev < cfg.gain_th) && (gain_now >= cfg.gain_th);
			gain_fall <= (gain_prev >= cfg.gain_th) && (gain_now < cfg.gain_th);

			tx_bb_rise <= tx_status.tx_bb_is_ongoing && !tx_bb_reg;
			tx_bb_fall <= !tx_status.tx_bb_is_ongoing && tx_bb_reg;
			tx_rf_rise <= tx_status.tx_rf_is_ongoing && !tx_rf_reg;
			tx_rf_fall <= !tx_status.tx_rf_is_ongoing && tx_rf_reg;
		end
	end

	always_comb begin
		case (cfg.trigger_sel)
			trig_fcs_any: trig_cond = rx_events.fcs_in_strobe | cfg.free_run;
			trig_fcs_ok: trig_cond = rx_events.fcs_in_strobe & rx_events.fcs_ok;
			trig_fcs_bad: trig_cond = rx_events.fcs_in_strobe & ~rx_events.fcs_ok;
			trig_header_ok:
				trig_cond = rx_events.pkt_header_valid_strobe & rx_events.pkt_header_valid;
			trig_header_bad:
				trig_cond = rx_events.pkt_header_valid_strobe & ~rx_events.pkt_header_valid;
			trig_long_preamble: trig_cond = rx_events.long_preamble_detected;
			trig_short_preamble: trig_cond = rx_events.short_preamble_detected;
			trig_rssi_rise: trig_cond = rssi_rise;
			trig_rssi_fall: trig_cond = rssi_fall;
			trig_agc_unlock: trig_cond = agc_unlock;
			trig_agc_lock: trig_cond = agc_lock;
			trig_gain_rise: trig_cond = gain_rise;
			trig_gain_fall: trig_cond = gain_fall;
			trig_phy_tx_done: trig_cond = tx_status.phy_tx_done;
			trig_tx_bb_rise: trig_cond = tx_bb_rise;
			trig_tx_bb_fall: trig_cond = tx_bb_fall;
			trig_tx_rf_rise: trig_cond = tx_rf_rise;
			trig_tx_rf_fall: trig_cond = tx_rf_fall;
			default: trig_cond = rx_events.fcs_in_strobe; // any other code
		endcase
	end

	always_ff @(posedge clk) begin
		if (!rstn) begin
			trigger <= 1'b0;
		end else begin
			trigger <= cfg.iq_capture & trig_cond;
		end
	end

endmodule

// ==== src/iq_ring_buffer.sv ====
// iq_ring_buffer: pre-trigger sample memory with free-running write pointer
module iq_ring_buffer import side_ch_pkg::*; (
	input  logic clk,
	input  logic rstn,
	input  logic [dma_data_width-1:0] wr_data,
	input  logic wr_en,
	input  logic [iq_addr_width-1:0] rd_addr,
	output logic [dma_data_width-1:0] rd_data,
	output logic [iq_addr_width-1:0] wr_addr
);

	logic [dma_data_width-1:0] mem [max_num_dma_symbol];

	// wraps naturally at the memory depth
	always_ff @(posedge clk) begin
		if (!rstn) begin
			wr_addr <= '0;
		end else if (wr_en) begin
			wr_addr <= wr_addr + 1'b1;
		end
	end

	always_ff @(posedge clk) begin
		if (wr_en) begin
			mem[wr_addr] <= wr_data;
		end
	end

	// one cycle read latency
	always_ff @(posedge clk) begin
		rd_data <= mem[rd_addr];
	end

endmodule

// ==== src/iq_capture_streamer.sv ====
// iq_capture_streamer: trigger wait, space check, timestamp header and sample window
module iq_capture_streamer import side_ch_pkg::*; (
	input  logic clk,
	input  logic rstn,
	input  capture_cfg_t cfg,
	input  logic trigger,
	input  logic sample_strobe,
	input  logic [iq_addr_width-1:0] wr_addr,
	input  logic [dma_data_width-1:0] rd_data,
	input  logic [tsf_width-1:0] tsf_runtime_val,
	input  logic [dma_count_width-1:0] m_axis_data_count,
	output logic [iq_addr_width-1:0] rd_addr,
	output dma_word_t capture_out
);

	typedef enum logic [1:0] {st_wait, st_prepare, st_header, st_stream} state_t;

	state_t state;
	logic [iq_addr_width-1:0] raddr, raddr_next;
	logic [dma_count_width-1:0] iq_count;
	logic [tsf_width-1:0] tsf_lock;
	logic [dma_data_width-1:0] out_data;
	logic out_valid;
	logic space_ok;
	logic trig_take, hdr_load, smp_load;

	// room for header plus the whole window
	assign space_ok = (int'(max_num_dma_symbol_udp) - int'(m_axis_data_count))
		>= (int'(cfg.iq_len) + 1);

	assign trig_take = cfg.iq_capture && (state == st_wait) && trigger;
	assign hdr_load = cfg.iq_capture && (state == st_prepare) && space_ok;
	assign smp_load = cfg.iq_capture && (state == st_stream) && sample_strobe;

	// ram address looks one step ahead so rd_data always matches raddr
	always_comb begin
		raddr_next = raddr;
		if (trig_take) begin
			raddr_next = wr_addr - cfg.pre_trigger_len[iq_addr_width-1:0];
		end else if (smp_load) begin
			raddr_next = raddr + 1'b1;
		end
	end

	assign rd_addr = raddr_next;

	always_ff @(posedge clk) begin
		if (!rstn) begin
			state <= st_wait;
			raddr <= '0;
			iq_count <= '0;
			out_valid <= 1'b0;
		end else begin
			raddr <= raddr_next;
			out_valid <= hdr_load | smp_load;
			if (cfg.iq_capture) begin
				case (state)
					st_wait: begin
						iq_count <= '0;
						if (trigger)
							state <= st_prepare;
					end
					st_prepare: state <= space_ok ? st_header : st_wait;
					st_header: state <= (cfg.iq_len == '0) ? st_wait : st_stream; // header on port now
					st_stream: begin
						if (sample_strobe) begin
							iq_count <= iq_count + 1'b1;
							if (iq_count + 1'b1 >= cfg.iq_len)
								state <= st_wait; // window done
						end
					end
				endcase
			end
		end
	end

	always_ff @(posedge clk) begin
		if (trig_take)
			tsf_lock <= tsf_runtime_val;
		if (hdr_load)
			out_data <= tsf_lock;
		else if (smp_load)
			out_data <= rd_data;
	end

	assign capture_out.data = out_data;
	assign capture_out.valid = out_valid;

endmodule

// ==== src/dma_out_mux.sv ====
// dma_out_mux: auto start pulse detector and dma output mode selection
module dma_out_mux import side_ch_pkg::*; (
	input  logic clk,
	input  logic rstn,
	input  logic [1:0] mode,
	input  logic ext_start,
	input  logic slv_reg_wren_signal,
	input  logic [4:0] axi_awaddr_core,
	input  dma_word_t capture_in,
	input  logic [dma_data_width-1:0] data_to_pl,
	input  logic emptyn_to_pl,
	input  logic s_axis_tlast,
	output logic [dma_data_width-1:0] data_to_ps,
	output logic data_to_ps_valid,
	output logic m_axis_start_1trans,
	output logic pl_ask_data
);

	logic num_sym_wr;
	logic num_sym_wr_d1, num_sym_wr_d2;
	logic auto_start;

	assign num_sym_wr = slv_reg_wren_signal && (axi_awaddr_core == 5'(num_dma_symbol_reg_addr));

	// first cycle of a write to the symbol count register, one pulse per write
	always_ff @(posedge clk) begin
		if (!rstn) begin
			num_sym_wr_d1 <= 1'b0;
			num_sym_wr_d2 <= 1'b0;
			auto_start <= 1'b0;
		end else begin
			num_sym_wr_d1 <= num_sym_wr;
			num_sym_wr_d2 <= num_sym_wr_d1;
			auto_start <= num_sym_wr_d1 & ~num_sym_wr_d2;
		end
	end

	always_comb begin
		data_to_ps = '0;
		data_to_ps_valid = 1'b0;
		m_axis_start_1trans = 1'b0;
		pl_ask_data = 1'b0;
		case (mode)
			mode_loopback: begin // s_axis straight back out
				data_to_ps = data_to_pl;
				data_to_ps_valid = emptyn_to_pl;
				m_axis_start_1trans = s_axis_tlast;
				pl_ask_data = 1'b1;
			end
			mode_auto_start: begin
				data_to_ps = capture_in.data;
				data_to_ps_valid = capture_in.valid;
				m_axis_start_1trans = auto_start;
			end
			mode_ext_start: begin
				data_to_ps = capture_in.data;
				data_to_ps_valid = capture_in.valid;
				m_axis_start_1trans = ext_start;
			end
			default: ; // mode_idle, everything low
		endcase
	end

endmodule

// ==== src/side_ch_top.sv ====
// side_ch_top: iq capture side channel, packer, trigger, ring buffer, streamer, output mux
module side_ch_top import side_ch_pkg::*; (
	input  logic clk,
	input  logic rstn,
	input  iq_stream_t rx_iq,
	input  iq_stream_t openofdm_tx_iq,
	input  iq_stream_t tx_intf_iq,
	input  rx_events_t rx_events,
	input  tx_status_t tx_status,
	input  logic [gpio_status_width-1:0] gpio_status,
	input  logic signed [rssi_width-1:0] rssi_half_db,
	input  logic [tsf_width-1:0] tsf_runtime_val,
	input  capture_cfg_t cfg,
	input  logic [1:0] m_axis_start_mode,
	input  logic m_axis_start_ext_trigger,
	input  logic slv_reg_wren_signal,
	input  logic [4:0] axi_awaddr_core,
	input  logic [dma_count_width-1:0] m_axis_data_count,
	input  logic [dma_data_width-1:0] data_to_pl,
	input  logic emptyn_to_pl,
	input  logic s_axis_tlast,
	output logic [dma_data_width-1:0] data_to_ps,
	output logic data_to_ps_valid,
	output logic m_axis_start_1trans,
	output logic pl_ask_data
);

	logic [dma_data_width-1:0] sample_word;
	logic sample_strobe;
	logic trigger;
	logic [iq_addr_width-1:0] wr_addr;
	logic [iq_addr_width-1:0] rd_addr;
	logic [dma_data_width-1:0] rd_data;
	dma_word_t capture_word;

	iq_sample_packer u_packer (
		.clk(clk),
		.rstn(rstn),
		.rx_iq(rx_iq),
		.ofdm_tx_iq(openofdm_tx_iq),
		.intf_tx_iq(tx_intf_iq),
		.rx_events(rx_events),
		.tx_rf_is_ongoing(tx_status.tx_rf_is_ongoing),
		.rssi_half_db(rssi_half_db),
		.gpio_status(gpio_status),
		.cfg(cfg),
		.sample_word(sample_word),
		.sample_strobe(sample_strobe)
	);

	iq_trigger_select u_trigger (
		.clk(clk),
		.rstn(rstn),
		.cfg(cfg),
		.rx_events(rx_events),
		.tx_status(tx_status),
		.rssi_half_db(rssi_half_db),
		.gpio_status(gpio_status),
		.trigger(trigger)
	);

	iq_ring_buffer u_ring (
		.clk(clk),
		.rstn(rstn),
		.wr_data(sample_word),
		.wr_en(sample_strobe),
		.rd_addr(rd_addr),
		.rd_data(rd_data),
		.wr_addr(wr_addr)
	);

	iq_capture_streamer u_streamer (
		.clk(clk),
		.rstn(rstn),
		.cfg(cfg),
		.trigger(trigger),
		.sample_strobe(sample_strobe),
		.wr_addr(wr_addr),
		.rd_data(rd_data),
		.tsf_runtime_val(tsf_runtime_val),
		.m_axis_data_count(m_axis_data_count),
		.rd_addr(rd_addr),
		.capture_out(capture_word)
	);

	dma_out_mux u_out_mux (
		.clk(clk),
		.rstn(rstn),
		.mode(m_axis_start_mode),
		.ext_start(m_axis_start_ext_trigger),
		.slv_reg_wren_signal(slv_reg_wren_signal),
		.axi_awaddr_core(axi_awaddr_core),
		.capture_in(capture_word),
		.data_to_pl(data_to_pl),
		.emptyn_to_pl(emptyn_to_pl),
		.s_axis_tlast(s_axis_tlast),
		.data_to_ps(data_to_ps),
		.data_to_ps_valid(data_to_ps_valid),
		.m_axis_start_1trans(m_axis_start_1trans),
		.pl_ask_data(pl_ask_data)
	);

endmodule

// ==== tb/tb_clkgen.sv ====
// tb_clkgen: 8 ns testbench clock and 16-cycle active low reset
module tb_clkgen (
	output logic clk,
	output logic rstn
);
	timeunit 1ns;
	timeprecision 100ps;

	initial begin
		clk = 1'b0;
		forever #4 clk = ~clk; // 8 ns period
	end

	initial begin
		rstn = 1'b0;
		repeat (16) @(posedge clk);
		@(negedge clk);
		rstn = 1'b1; // released on a falling edge like all stimulus
	end
endmodule

// ==== tb/side_ch_tb.sv ====
// side_ch_tb: directed tests for loopback, capture windows, triggers, space check, auto start
module side_ch_tb import side_ch_pkg::*; ();
	timeunit 1ns;
	timeprecision 100ps;

	// stimulus adds up to well under 2k cycles
	localparam int max_cycles = 20000;

	logic clk;
	logic rstn;
	iq_stream_t rx_iq, openofdm_tx_iq, tx_intf_iq;
	rx_events_t rx_events;
	tx_status_t tx_status;
	logic [gpio_status_width-1:0] gpio_status;
	logic signed [rssi_width-1:0] rssi_half_db;
	logic [tsf_width-1:0] tsf_runtime_val;
	capture_cfg_t cfg;
	logic [1:0] m_axis_start_mode;
	logic m_axis_start_ext_trigger;
	logic slv_reg_wren_signal;
	logic [4:0] axi_awaddr_core;
	logic [dma_count_width-1:0] m_axis_data_count;
	logic [dma_data_width-1:0] data_to_pl;
	logic emptyn_to_pl;
	logic s_axis_tlast;
	logic [dma_data_width-1:0] data_to_ps;
	logic data_to_ps_valid;
	logic m_axis_start_1trans;
	logic pl_ask_data;

	int seed;
	int cycles;
	int sample_idx;
	logic fcs_flag_model; // expected state of the packer's fcs-ok bit
	logic collect;
	logic [dma_data_width-1:0] exp_mem [256]; // expected word per sample index
	logic [dma_data_width-1:0] got_q [$];

	tb_clkgen u_clkgen (.clk(clk), .rstn(rstn));

	side_ch_top UUT (.*);

	always @(posedge clk) begin
		cycles++;
		if (cycles >= max_cycles) begin
			$display("timeout: run did not finish within %0d cycles", max_cycles);
			$display("tests failed");
			$fatal(1, "timeout");
		end
	end

	// capture every valid dma word while a test listens
	always @(posedge clk) begin
		if (collect && data_to_ps_valid)
			got_q.push_back(data_to_ps);
	end

	task automatic check_value(input string name, input logic [63:0] exp, input logic [63:0] act);
		if (exp !== act) begin
			$display("ERR %s: expected %h, actual %h", name, exp, act);
			$display("tests failed");
			$fatal(1, "stopped at first mismatch");
		end
	endtask

	task automatic idle_cycles(input int n);
		repeat (n) @(negedge clk);
	endtask

	// word layout as the packer is specified to build it
	function automatic logic [63:0] expected_word(input logic [31:0] idx);
		if (cfg.dual_iq)
			return {~idx, idx};
		return {rx_events.demod_is_ongoing, tx_status.tx_rf_is_ongoing, fcs_flag_model,
			rssi_half_db, 10'd0, gpio_status, idx};
	endfunction

	task automatic push_samples(input int n, input logic gaps);
		int gap;
		for (int i = 0; i < n; i++) begin
			@(negedge clk);
			rx_iq.iq0 = sample_idx;
			rx_iq.iq1 = ~32'(sample_idx);
			rx_iq.strobe = 1'b1;
			exp_mem[sample_idx] = expected_word(sample_idx);
			sample_idx++;
			gap = gaps ? ($random(seed) & 3) : 0;
			if (gap > 0) begin
				@(negedge clk);
				rx_iq.strobe = 1'b0;
				repeat (gap - 1) @(negedge clk);
			end
		end
		@(negedge clk);
		rx_iq.strobe = 1'b0;
	endtask

	task automatic pulse_fcs(input logic ok);
		@(negedge clk);
		rx_events.fcs_in_strobe = 1'b1;
		rx_events.fcs_ok = ok;
		@(negedge clk);
		rx_events.fcs_in_strobe = 1'b0;
		rx_events.fcs_ok = 1'b0;
	endtask

	task automatic pulse_preamble(input logic long_pre);
		@(negedge clk);
		rx_events.long_preamble_detected = long_pre;
		rx_events.short_preamble_detected = !long_pre;
		@(negedge clk);
		rx_events.long_preamble_detected = 1'b0;
		rx_events.short_preamble_detected = 1'b0;
	endtask

	task automatic set_capture(input logic capture, input logic dual, input logic [4:0] code,
		input int pre, input int len);
		@(negedge clk);
		cfg.iq_capture = capture;
		cfg.dual_iq = dual;
		cfg.trigger_sel = code;
		cfg.pre_trigger_len = pre;
		cfg.iq_len = len;
	endtask

	task automatic check_window(input string name, input int first, input int len);
		check_value({name, " word count"}, len + 1, got_q.size());
		check_value({name, " header"}, tsf_runtime_val, got_q[0]);
		for (int k = 0; k < len; k++) begin
			check_value($sformatf("%s sample %0d", name, k), exp_mem[first + k], got_q[k + 1]);
		end
	endtask

	// strobes every cycle for 50 cycles, so a started window also drains
	task automatic watch_header(input string name, input logic fire);
		got_q.delete();
		collect = 1'b1;
		sample_idx = 0;
		push_samples(50, 1'b0);
		idle_cycles(4);
		collect = 1'b0;
		check_value(name, fire, got_q.size() != 0);
	endtask

	task automatic count_start_pulses(input string name, input logic [4:0] addr,
		input logic [11:0] expected);
		logic [11:0] seen;
		@(negedge clk);
		slv_reg_wren_signal = 1'b1;
		axi_awaddr_core = addr;
		for (int i = 0; i < 12; i++) begin
			@(posedge clk);
			seen[i] = m_axis_start_1trans;
			@(negedge clk);
			if (i == 4)
				slv_reg_wren_signal = 1'b0; // five cycle write
		end
		check_value(name, expected, seen);
	endtask

	task automatic test_loopback();
		logic [63:0] d;
		logic v, l;
		for (int i = 0; i < 16; i++) begin
			@(negedge clk);
			m_axis_start_mode = (i < 8) ? mode_loopback : mode_idle;
			d = {$random(seed), $random(seed)};
			v = 1'($random(seed));
			l = 1'($random(seed));
			data_to_pl = d;
			emptyn_to_pl = v;
			s_axis_tlast = l;
			@(posedge clk);
			if (i < 8) begin
				check_value("loopback data", d, data_to_ps);
				check_value("loopback valid", v, data_to_ps_valid);
				check_value("loopback start", l, m_axis_start_1trans);
				check_value("loopback ask", 1, pl_ask_data);
			end else begin
				check_value("idle data", 0, data_to_ps);
				check_value("idle flags", 0, {data_to_ps_valid, m_axis_start_1trans, pl_ask_data});
			end
		end
	endtask

	task automatic test_window();
		set_capture(1'b1, 1'b1, trig_fcs_any, 8, 16);
		m_axis_start_mode = mode_ext_start;
		// start line follows the external trigger, no data request
		@(negedge clk);
		m_axis_start_ext_trigger = 1'b1;
		@(posedge clk);
		check_value("ext start high", 1, m_axis_start_1trans);
		check_value("ext start ask", 0, pl_ask_data);
		@(negedge clk);
		m_axis_start_ext_trigger = 1'b0;
		@(posedge clk);
		check_value("ext start low", 0, m_axis_start_1trans);
		sample_idx = 0;
		got_q.delete();
		collect = 1'b1;
		push_samples(40, 1'b1);
		idle_cycles(2);
		pulse_fcs(1'b0);
		idle_cycles(2);
		push_samples(30, 1'b1);
		idle_cycles(20);
		collect = 1'b0;
		check_window("dual window", 40 - 8, 16);
	endtask

	task automatic test_status_format();
		set_capture(1'b0, 1'b0, trig_short_preamble, 16, 16);
		rssi_half_db = -11'sd37;
		gpio_status = 8'ha5;
		rx_events.demod_is_ongoing = 1'b1;
		tx_status.tx_rf_is_ongoing = 1'b1;
		pulse_fcs(1'b1);
		fcs_flag_model = 1'b1;
		@(negedge clk);
		cfg.iq_capture = 1'b1;
		sample_idx = 0;
		got_q.delete();
		collect = 1'b1;
		push_samples(10, 1'b1);
		pulse_preamble(1'b1); // clears the fcs-ok bit
		fcs_flag_model = 1'b0;
		push_samples(10, 1'b1);
		idle_cycles(2);
		pulse_preamble(1'b0);
		idle_cycles(2);
		push_samples(24, 1'b1);
		idle_cycles(20);
		collect = 1'b0;
		check_window("status window", 20 - 16, 16);
		@(negedge clk);
		rx_events.demod_is_ongoing = 1'b0;
		tx_status.tx_rf_is_ongoing = 1'b0;
	endtask

	task automatic test_triggers();
		set_capture(1'b1, 1'b1, trig_rssi_rise, 4, 4);
		m_axis_start_mode = mode_auto_start; // capture words on the auto start path
		cfg.rssi_th = -11'sd60;
		rssi_half_db = -11'sd80;
		idle_cycles(4);
		rssi_half_db = -11'sd50;
		watch_header("rssi upward crossing", 1'b1);
		rssi_half_db = -11'sd80;
		watch_header("rssi downward crossing", 1'b0);
		cfg.trigger_sel = trig_fcs_ok;
		pulse_fcs(1'b0);
		watch_header("fcs_ok with bad fcs", 1'b0);
		pulse_fcs(1'b1);
		watch_header("fcs_ok with good fcs", 1'b1);
		cfg.trigger_sel = trig_tx_rf_fall;
		tx_status.tx_rf_is_ongoing = 1'b1;
		watch_header("tx_rf rising edge", 1'b0);
		tx_status.tx_rf_is_ongoing = 1'b0;
		watch_header("tx_rf falling edge", 1'b1);
	endtask

	task automatic test_space_check();
		set_capture(1'b1, 1'b1, trig_fcs_any, 8, 16);
		m_axis_data_count = 14'(max_num_dma_symbol_udp - 16); // one word short
		got_q.delete();
		collect = 1'b1;
		pulse_fcs(1'b0);
		idle_cycles(50);
		collect = 1'b0;
		check_value("space short", 0, got_q.size());
		@(negedge clk);
		m_axis_data_count = 14'(max_num_dma_symbol_udp - 17); // exact fit
		pulse_fcs(1'b0);
		watch_header("space exact fit", 1'b1);
		m_axis_data_count = '0;
	endtask

	task automatic test_auto_start();
		set_capture(1'b0, 1'b1, trig_fcs_any, 8, 16);
		m_axis_start_mode = mode_auto_start;
		count_start_pulses("auto start reg 2", 5'(num_dma_symbol_reg_addr), 12'b0000_0000_0100);
		count_start_pulses("auto start reg 3", 5'd3, 12'b0);
	endtask

	initial begin
		seed = 32'hd04c;
		cycles = 0;
		sample_idx = 0;
		fcs_flag_model = 1'b0;
		collect = 1'b0;
		rx_iq = '0;
		openofdm_tx_iq = '0;
		tx_intf_iq = '0;
		rx_events = '0;
		tx_status = '0;
		gpio_status = '0;
		rssi_half_db = '0;
		tsf_runtime_val = 64'h0123_4567_89ab_cdef; // held for the whole run
		cfg = '0;
		m_axis_start_mode = mode_idle;
		m_axis_start_ext_trigger = 1'b0;
		slv_reg_wren_signal = 1'b0;
		axi_awaddr_core = '0;
		m_axis_data_count = '0;
		data_to_pl = '0;
		emptyn_to_pl = 1'b0;
		s_axis_tlast = 1'b0;
		wait (rstn === 1'b1);
		idle_cycles(2);
		test_loopback();
		test_window();
		test_status_format();
		test_triggers();
		test_space_check();
		test_auto_start();
		$display("all tests passed");
		$finish;
	end
endmodule

// ==== side_ch.f ====
src/side_ch_pkg.sv
src/iq_sample_packer.sv
src/iq_trigger_select.sv
src/iq_ring_buffer.sv
src/iq_capture_streamer.sv
src/dma_out_mux.sv
src/side_ch_top.sv
tb/tb_clkgen.sv
tb/side_ch_tb.sv

// ==== Bender.yml ====
package:
  name: side_ch

sources:
  - src/side_ch_pkg.sv
  - src/iq_sample_packer.sv
  - src/iq_trigger_select.sv
  - src/iq_ring_buffer.sv
  - src/iq_capture_streamer.sv
  - src/dma_out_mux.sv
  - src/side_ch_top.sv
  - target: test
    files:
      - tb/tb_clkgen.sv
      - tb/side_ch_tb.sv
